// File: verilog.f
design/core_mem_pkg.sv
design/core_wb_bridge.sv
design/wb_byte_ram.sv
design/core_mem_top.sv
test/core_wb_bridge_checker.sv
test/core_mem_tb.sv

// File: Makefile
# Verilator build and run for the memory subsystem testbench

TOP := core_mem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

// File: test/core_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_tb
  import core_mem_pkg::*;
;

  localparam int CLK_NS       = 8;
  localparam int GNT_LAT      = 3;   // Accepting edge to gnt edge
  localparam int MAX_WAIT     = 20;
  localparam int TRANS_BUDGET = 36;  // Transactions issued below
  localparam int WATCHDOG_NS  = TRANS_BUDGET * 8 * CLK_NS + 20 * CLK_NS;

  logic      clk_core  = 1'b0;
  logic      rst_i     = 1'b1;
  core_req_t instr_req = '0;
  core_req_t data_req  = '0;
  core_rsp_t instr_rsp;
  core_rsp_t data_rsp;

  int     errors = 0;
  int     seed   = 32'hfd27;
  bit     in_reply [2];        // Bridge still in BR_REPLY after a grant
  word_t  instr_model [INSTR_WORDS];
  word_t  data_model [DATA_WORDS];
  addr_t  addr_list [8];

  core_mem_top DUT (
    .clk_core    (clk_core),
    .rst_i       (rst_i),
    .instr_req_i (instr_req),
    .instr_rsp_o (instr_rsp),
    .data_req_i  (data_req),
    .data_rsp_o  (data_rsp)
  );

  bind core_wb_bridge core_wb_bridge_checker u_proto_chk (
    .clk_core   (clk_core),
    .rst_i      (rst_i),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o),
    .wb_req_o   (wb_req_o),
    .wb_rsp_i   (wb_rsp_i)
  );

  always #(CLK_NS / 2) clk_core = ~clk_core;

  function automatic string port_name(bit port);
    return port ? "data_rsp_o" : "instr_rsp_o";
  endfunction

  function automatic int unsigned depth_of(bit port);
    return port ? DATA_WORDS : INSTR_WORDS;
  endfunction

  // Old bytes where be is 0, new bytes where be is 1
  function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic addr_t rand_addr(int unsigned depth);
    int unsigned r;
    r = $unsigned($random(seed));
    return addr_t'((r % depth) * 4);
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // Drives one request from a falling edge, holds it and waits for gnt
  task automatic access(input bit port, input logic we, input sel_t be, input addr_t addr,
                        input word_t wdata, output core_rsp_t rsp);
    core_req_t req;
    int        lat;
    int        exp_lat;
    req     = '{valid: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    exp_lat = GNT_LAT + (in_reply[port] ? 1 : 0);  // Valid ignored during BR_REPLY
    if (port) data_req = req;
    else instr_req = req;
    lat = 0;
    rsp = '0;
    while (!rsp.gnt && lat <= MAX_WAIT) begin
      @(negedge clk_core);
      rsp = port ? data_rsp : instr_rsp;
      if (!rsp.gnt) lat++;
    end
    assert (rsp.gnt) else begin
      errors++;
      $display("No grant on %s within %0d cycles", port_name(port), MAX_WAIT);
    end
    check_word({port_name(port), ".gnt latency"}, word_t'(exp_lat), word_t'(lat));
    in_reply[port] = 1'b1;
  endtask

  task automatic release_port(input bit port);
    if (port) data_req = '0;
    else instr_req = '0;
    in_reply[port] = 1'b0;
    @(negedge clk_core);
  endtask

  task automatic do_write(input bit port, input addr_t addr, input word_t wdata,
                          input sel_t be, input bit hold);
    core_rsp_t rsp;
    logic      exp_err;
    exp_err = (addr >= depth_of(port) * 4);
    access(port, 1'b1, be, addr, wdata, rsp);
    check_bit({port_name(port), ".err"}, exp_err, rsp.err);
    check_bit({port_name(port), ".rvalid"}, 1'b0, rsp.rvalid);
    if (!exp_err && port) begin
      data_model[addr[10:2]] = merge_bytes(data_model[addr[10:2]], wdata, be);
    end else if (!exp_err) begin
      instr_model[addr[9:2]] = merge_bytes(instr_model[addr[9:2]], wdata, be);
    end
    if (!hold) release_port(port);
  endtask

  task automatic do_read(input bit port, input addr_t addr, input bit hold);
    core_rsp_t rsp;
    logic      exp_err;
    word_t     exp_data;
    exp_err  = (addr >= depth_of(port) * 4);
    exp_data = port ? data_model[addr[10:2]] : instr_model[addr[9:2]];
    access(port, 1'b0, 4'hf, addr, '0, rsp);
    check_bit({port_name(port), ".err"}, exp_err, rsp.err);
    check_bit({port_name(port), ".rvalid"}, !exp_err, rsp.rvalid);
    if (!exp_err) check_word({port_name(port), ".rdata"}, exp_data, rsp.rdata);
    if (!hold) release_port(port);
  endtask

  initial begin
    int proto_errs;
    repeat (3) @(posedge clk_core);
    @(negedge clk_core);
    rst_i = 1'b0;

    // Full word write and read back on random data addresses
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = rand_addr(DATA_WORDS);
      do_write(1'b1, addr_list[i], word_t'($random(seed)), 4'hf, 1'b0);
    end
    for (int i = 0; i < 8; i++) do_read(1'b1, addr_list[i], 1'b0);

    // Byte enable merge
    do_write(1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf, 1'b0);
    do_write(1'b1, 32'h0000_0100, 32'haabb_ccdd, 4'b0101, 1'b0);
    do_read(1'b1, 32'h0000_0100, 1'b0);
    do_write(1'b0, 32'h0000_0020, 32'h5566_7788, 4'hf, 1'b0);
    do_write(1'b0, 32'h0000_0020, 32'hdead_beef, 4'b1010, 1'b0);
    do_read(1'b0, 32'h0000_0020, 1'b0);

    // Same address on both ports at once
    fork
      do_write(1'b0, 32'h0000_0040, 32'h0123_4567, 4'hf, 1'b0);
      do_write(1'b1, 32'h0000_0040, 32'h89ab_cdef, 4'hf, 1'b0);
    join
    fork
      do_read(1'b0, 32'h0000_0040, 1'b0);
      do_read(1'b1, 32'h0000_0040, 1'b0);
    join

    // Past the instruction RAM but inside the data RAM
    do_write(1'b0, INSTR_WORDS * 4 + 32'h10, 32'h0bad_0bad, 4'hf, 1'b0);
    do_read(1'b0, INSTR_WORDS * 4 + 32'h10, 1'b0);
    do_write(1'b1, INSTR_WORDS * 4 + 32'h10, 32'h600d_600d, 4'hf, 1'b0);
    do_read(1'b1, INSTR_WORDS * 4 + 32'h10, 1'b0);

    // Back to back requests with each new one driven right after gnt
    do_write(1'b1, 32'h0000_0200, 32'h0000_0010, 4'hf, 1'b0);
    do_read(1'b1, 32'h0000_0200, 1'b1);
    do_write(1'b1, 32'h0000_0200, data_model[9'h080] + 32'd1, 4'hf, 1'b1);
    do_write(1'b1, 32'h0000_0200, 32'h0000_5500, 4'b0010, 1'b1);
    do_read(1'b1, 32'h0000_0200, 1'b1);
    do_read(1'b1, 32'h0000_0200, 1'b0);

    repeat (4) @(negedge clk_core);
    proto_errs = DUT.u_instr_bridge.u_proto_chk.fail_cnt +
                 DUT.u_data_bridge.u_proto_chk.fail_cnt;
    $display("Summary: %0d check errors, %0d assertion failures", errors, proto_errs);
    if (errors == 0 && proto_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog sized from the transaction count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/core_wb_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol properties bound into every core port bridge
module core_wb_bridge_checker
  import core_mem_pkg::*;
(
  input wire logic      clk_core,
  input wire logic      rst_i,
  input wire core_req_t core_req_i,
  input wire core_rsp_t core_rsp_o,
  input wire wb_req_t   wb_req_o,
  input wire wb_rsp_t   wb_rsp_i
);

  int fail_cnt = 0;  // Failed properties so far

  gnt_single: assert property (@(posedge clk_core) disable iff (rst_i)
    core_rsp_o.gnt |=> !core_rsp_o.gnt)
  else begin
    fail_cnt++;
    $error("gnt high for more than one cycle");
  end

  // Read data is only flagged on the grant of a read
  rvalid_on_read: assert property (@(posedge clk_core) disable iff (rst_i)
    core_rsp_o.rvalid |-> core_rsp_o.gnt && !wb_req_o.we)
  else begin
    fail_cnt++;
    $error("rvalid without gnt or on a write");
  end

  rvalid_err_excl: assert property (@(posedge clk_core) disable iff (rst_i)
    !(core_rsp_o.rvalid && core_rsp_o.err))
  else begin
    fail_cnt++;
    $error("rvalid and err high together");
  end

  stb_is_cyc: assert property (@(posedge clk_core) disable iff (rst_i)
    wb_req_o.stb == wb_req_o.cyc)
  else begin
    fail_cnt++;
    $error("stb differs from cyc");
  end

  cyc_held: assert property (@(posedge clk_core) disable iff (rst_i)
    wb_req_o.cyc && !wb_rsp_i.ack && !wb_rsp_i.err |=> wb_req_o.cyc && wb_req_o.stb)
  else begin
    fail_cnt++;
    $error("cyc dropped before ack or err");
  end

  // A bus cycle starts only from a valid request and carries its address
  cyc_from_req: assert property (@(posedge clk_core) disable iff (rst_i)
    $rose(wb_req_o.cyc) |-> $past(core_req_i.valid) && wb_req_o.adr == $past(core_req_i.addr))
  else begin
    fail_cnt++;
    $error("bus cycle started without a matching request");
  end

  reset_quiet: assert property (@(posedge clk_core)
    $fell(rst_i) |-> !core_rsp_o.gnt && !core_rsp_o.rvalid && !core_rsp_o.err &&
                     !wb_req_o.cyc && !wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err)
  else begin
    fail_cnt++;
    $error("outputs not idle in the first cycle after reset");
  end

endmodule

`default_nettype wire

// File: design/core_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction and data memories, each behind its own bridge
module core_mem_top
  import core_mem_pkg::*;
(
  input  wire logic      clk_core,
  input  wire logic      rst_i,

  // Instruction port
  input  wire core_req_t instr_req_i,
  output core_rsp_t      instr_rsp_o,

  // Data port
  input  wire core_req_t data_req_i,
  output core_rsp_t      data_rsp_o
);

  wb_req_t instr_wb_req;
  wb_rsp_t instr_wb_rsp;
  wb_req_t data_wb_req;
  wb_rsp_t data_wb_rsp;

  core_wb_bridge u_instr_bridge (
    .clk_core   (clk_core),
    .rst_i      (rst_i),
    .core_req_i (instr_req_i),
    .core_rsp_o (instr_rsp_o),
    .wb_req_o   (instr_wb_req),
    .wb_rsp_i   (instr_wb_rsp)
  );

  wb_byte_ram #(
    .DEPTH (INSTR_WORDS)  // Smaller instruction store
  ) u_instr_ram (
    .clk_core (clk_core),
    .rst_i    (rst_i),
    .wb_req_i (instr_wb_req),
    .wb_rsp_o (instr_wb_rsp)
  );

  core_wb_bridge u_data_bridge (
    .clk_core   (clk_core),
    .rst_i      (rst_i),
    .core_req_i (data_req_i),
    .core_rsp_o (data_rsp_o),
    .wb_req_o   (data_wb_req),
    .wb_rsp_i   (data_wb_rsp)
  );

  wb_byte_ram #(
    .DEPTH (DATA_WORDS)
  ) u_data_ram (
    .clk_core (clk_core),
    .rst_i    (rst_i),
    .wb_req_i (data_wb_req),
    .wb_rsp_o (data_wb_rsp)
  );

endmodule

`default_nettype wire

// File: design/wb_byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave RAM, word wide with byte selects
module wb_byte_ram
  import core_mem_pkg::*;
#(
  parameter int unsigned DEPTH = DATA_WORDS
) (
  input  wire logic    clk_core,
  input  wire logic    rst_i,

  input  wire wb_req_t wb_req_i,
  output wb_rsp_t      wb_rsp_o
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t mem [DEPTH];

  wait_cnt_t wait_cnt_q;
  logic      ack_q;
  logic      err_q;
  word_t     rdata_q;

  logic        active;
  logic        respond;
  logic        in_range;
  logic [31:0] word_idx;
  logic [IDX_W-1:0] mem_idx;

  // Byte address to word index
  assign word_idx = {2'b00, wb_req_i.adr[31:2]};
  assign mem_idx  = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < DEPTH);

  // Busy while the master holds the strobe and no answer is out yet
  assign active  = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  assign respond = active && (wait_cnt_q == wait_cnt_t'(MEM_WAIT));

  always_ff @(posedge clk_core) begin
    if (rst_i) begin
      wait_cnt_q <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      ack_q <= 1'b0;  // Single cycle answer
      err_q <= 1'b0;
      if (respond) begin
        wait_cnt_q <= '0;
        ack_q      <= in_range;
        err_q      <= !in_range;
      end else if (active) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
        wait_cnt_q <= '0;
      end
    end
  end

  // Out of range accesses never touch the array
  always_ff @(posedge clk_core) begin
    if (respond && in_range) begin
      if (wb_req_i.we) begin
        for (int b = 0; b < BYTES; b++) begin
          if (wb_req_i.sel[b]) begin
            mem[mem_idx][b*BYTE_W +: BYTE_W] <= wb_req_i.dat[b*BYTE_W +: BYTE_W];
          end
        end
      end else begin
        rdata_q <= mem[mem_idx];
      end
    end
  end

  assign wb_rsp_o = '{
    ack: ack_q,
    err: err_q,
    dat: rdata_q
  };

endmodule

`default_nettype wire

// File: design/core_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// One core port to one Wishbone classic master
module core_wb_bridge
  import core_mem_pkg::*;
(
  input  wire logic      clk_core,
  input  wire logic      rst_i,

  input  wire core_req_t core_req_i,
  output core_rsp_t      core_rsp_o,

  output wb_req_t        wb_req_o,
  input  wire wb_rsp_t   wb_rsp_i
);

  bridge_state_t state_q;
  bridge_state_t state_d;

  // Control registers
  logic  bus_q;      // Drives both cyc and stb
  logic  gnt_q;
  logic  rvalid_q;
  logic  err_q;

  // Latched request and reply payload
  logic  we_q;
  sel_t  sel_q;
  addr_t adr_q;
  word_t dat_q;
  word_t rdata_q;

  logic  accept;
  logic  bus_done;

  // Valid is only looked at in idle, so the old item shown during
  // BR_REPLY is never taken twice
  assign accept   = (state_q == BR_IDLE) && core_req_i.valid;
  assign bus_done = (state_q == BR_BUS) && (wb_rsp_i.ack || wb_rsp_i.err);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      BR_IDLE: begin
        if (accept) begin
          state_d = BR_BUS;
        end
      end
      BR_BUS: begin
        if (bus_done) begin
          state_d = BR_REPLY;
        end
      end
      BR_REPLY: begin
        state_d = BR_IDLE;  // Grant lasts one cycle
      end
      default: begin
        state_d = BR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_core) begin
    if (rst_i) begin
      state_q  <= BR_IDLE;
      bus_q    <= 1'b0;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      if (accept) begin
        bus_q <= 1'b1;
      end
      if (bus_done) begin
        bus_q    <= 1'b0;
        gnt_q    <= 1'b1;
        err_q    <= wb_rsp_i.err;
        rvalid_q <= wb_rsp_i.ack && !we_q;  // Only acknowledged reads
      end
    end
  end

  // Request fields stay frozen for the whole bus cycle
  always_ff @(posedge clk_core) begin
    if (accept) begin
      we_q  <= core_req_i.we;
      sel_q <= core_req_i.be;
      adr_q <= core_req_i.addr;
      dat_q <= core_req_i.wdata;
    end
    if (bus_done && !we_q) begin
      rdata_q <= wb_rsp_i.dat;
    end
  end

  assign wb_req_o = '{
    cyc: bus_q,
    stb: bus_q,
    we:  we_q,
    sel: sel_q,
    adr: adr_q,
    dat: dat_q
  };

  assign core_rsp_o = '{
    gnt:    gnt_q,
    rvalid: rvalid_q,
    err:    err_q,
    rdata:  rdata_q
  };

endmodule

`default_nettype wire

// File: design/core_mem_pkg.sv
`default_nettype none

package core_mem_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int BYTES  = DATA_W / BYTE_W;

  // Cycles between stb seen and ack or err
  localparam int MEM_WAIT = 1;
  localparam int WAIT_W   = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

  // Memory depths in words
  localparam int unsigned INSTR_WORDS = 256;
  localparam int unsigned DATA_WORDS  = 512;

  typedef logic [ADDR_W-1:0] addr_t;   // Byte address
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BYTES-1:0]  sel_t;    // Bit n enables byte n
  typedef logic [WAIT_W-1:0] wait_cnt_t;

  // Core side request held until gnt
  typedef struct packed {
    logic  valid;
    logic  we;
    sel_t  be;
    addr_t addr;
    word_t wdata;
  } core_req_t;

  // One cycle reply to the core
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    word_t rdata;
  } core_rsp_t;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    word_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_BUS,
    BR_REPLY
  } bridge_state_t;

endpackage

`default_nettype wire
